// ==== rtl/smooth_pkg.sv ====
package smooth_pkg;

  // ************************************************************
  // AXI4-Lite types
  // ************************************************************

  typedef logic [3:0]  axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [1:0]  axil_resp_t;

  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  // master side, all channels
  typedef struct packed {
    logic       awvalid;
    axil_addr_t awaddr;
    logic       wvalid;
    axil_data_t wdata;
    logic [3:0] wstrb;
    logic       bready;
    logic       arvalid;
    axil_addr_t araddr;
    logic       rready;
  } axil_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    axil_resp_t bresp;
    logic       arready;
    logic       rvalid;
    axil_data_t rdata;
    axil_resp_t rresp;
  } axil_rsp_t;

  // ************************************************************
  // register map and filter modes
  // ************************************************************

  localparam axil_addr_t ADDR_CTRL  = 4'h0;  // mode in [2:0], flush in [4]
  localparam axil_addr_t ADDR_COUNT = 4'h4;  // output sample count
  localparam int CTRL_FLUSH_BIT     = 4;

  localparam int TAP_COUNT = 16;  // delay line depth

  typedef enum logic [2:0] {
    MODE_BYPASS     = 3'd0,
    MODE_AVG2       = 3'd1,
    MODE_AVG4       = 3'd2,
    MODE_AVG8       = 3'd3,
    MODE_AVG16      = 3'd4,
    MODE_WEIGHT4    = 3'd5,
    MODE_WEIGHT5    = 3'd6,
    MODE_BYPASS_ALT = 3'd7
  } filt_mode_e;

endpackage

// ==== rtl/axil_ctrl_regs.sv ====
`timescale 1ns/1ps

module axil_ctrl_regs (
  input  logic                   clk,
  input  logic                   reset_n,
  input  smooth_pkg::axil_req_t  ctrl_req,
  input  logic                   out_valid,
  output smooth_pkg::axil_rsp_t  ctrl_rsp,
  output smooth_pkg::filt_mode_e mode,
  output logic                   flush
);

  import smooth_pkg::*;

  typedef enum logic {W_IDLE, W_RESP} wr_state_e;
  typedef enum logic {R_IDLE, R_RESP} rd_state_e;

  wr_state_e  wr_state;
  rd_state_e  rd_state;
  logic       awready_q;  // drives awready and wready
  logic       bvalid_q;
  axil_resp_t bresp_q;
  logic       arready_q;
  logic       rvalid_q;
  axil_data_t rdata_q;
  axil_resp_t rresp_q;
  axil_data_t out_count;
  logic       wr_fire;
  logic       rd_fire;

  assign wr_fire = awready_q && ctrl_req.awvalid && ctrl_req.wvalid;
  assign rd_fire = arready_q && ctrl_req.arvalid;

  // ************************************************************
  // write channel
  // ************************************************************

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_state  <= W_IDLE;
      awready_q <= 1'b0;
      bvalid_q  <= 1'b0;
      mode      <= MODE_BYPASS;
      flush     <= 1'b0;
    end else begin
      flush <= 1'b0;  // single cycle pulse
      case (wr_state)
        W_IDLE: begin
          if (wr_fire) begin
            awready_q <= 1'b0;
            bvalid_q  <= 1'b1;
            wr_state  <= W_RESP;
            if (ctrl_req.awaddr == ADDR_CTRL) begin
              mode    <= filt_mode_e'(ctrl_req.wdata[2:0]);
              flush   <= ctrl_req.wdata[CTRL_FLUSH_BIT];
              bresp_q <= RESP_OKAY;
            end else begin
              bresp_q <= RESP_SLVERR;  // COUNT is read-only
            end
          end else if (ctrl_req.awvalid && ctrl_req.wvalid) begin
            awready_q <= 1'b1;  // wait for address and data together
          end
        end
        W_RESP: begin
          if (ctrl_req.bready) begin
            bvalid_q <= 1'b0;
            wr_state <= W_IDLE;
          end
        end
      endcase
    end
  end

  // ************************************************************
  // read channel
  // ************************************************************

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rd_state  <= R_IDLE;
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      case (rd_state)
        R_IDLE: begin
          if (rd_fire) begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b1;
            rd_state  <= R_RESP;
            case (ctrl_req.araddr)
              ADDR_CTRL: begin
                rdata_q <= axil_data_t'(mode);  // flush bit reads as zero
                rresp_q <= RESP_OKAY;
              end
              ADDR_COUNT: begin
                rdata_q <= out_count;
                rresp_q <= RESP_OKAY;
              end
              default: begin
                rdata_q <= '0;
                rresp_q <= RESP_SLVERR;
              end
            endcase
          end else if (ctrl_req.arvalid) begin
            arready_q <= 1'b1;
          end
        end
        R_RESP: begin
          if (ctrl_req.rready) begin  // rdata stays put until taken
            rvalid_q <= 1'b0;
            rd_state <= R_IDLE;
          end
        end
      endcase
    end
  end

  // output sample counter, wraps
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      out_count <= '0;
    end else if (out_valid) begin
      out_count <= out_count + 1'b1;
    end
  end

  always_comb begin
    ctrl_rsp.awready = awready_q;
    ctrl_rsp.wready  = awready_q;
    ctrl_rsp.bvalid  = bvalid_q;
    ctrl_rsp.bresp   = bresp_q;
    ctrl_rsp.arready = arready_q;
    ctrl_rsp.rvalid  = rvalid_q;
    ctrl_rsp.rdata   = rdata_q;
    ctrl_rsp.rresp   = rresp_q;
  end

endmodule

// ==== rtl/tap_delay_line.sv ====
`timescale 1ns/1ps

module tap_delay_line #(
  parameter int SAMPLE_WIDTH = 24
) (
  input  logic                                                 clk,
  input  logic                                                 reset_n,
  input  logic                                                 flush,
  input  logic                                                 in_valid,
  input  logic signed [SAMPLE_WIDTH-1:0]                       in_sample,
  output logic signed [smooth_pkg::TAP_COUNT-1:0][SAMPLE_WIDTH-1:0] taps,
  output logic                                                 shifted
);

  import smooth_pkg::*;

  // ************************************************************
  // sample history, taps[0] is the newest
  // ************************************************************

  always_ff @(posedge clk) begin
    if (!reset_n || flush) begin
      taps <= '0;  // flush beats a new sample
    end else if (in_valid) begin
      taps <= {taps[TAP_COUNT-2:0], in_sample};
    end
  end

  // new tap set strobe for the filter
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      shifted <= 1'b0;
    end else begin
      shifted <= in_valid && !flush;
    end
  end

endmodule

// ==== rtl/tap_filter.sv ====
`timescale 1ns/1ps

module tap_filter #(
  parameter int SAMPLE_WIDTH = 24
) (
  input  logic                                                 clk,
  input  logic                                                 reset_n,
  input  logic                                                 flush,
  input  smooth_pkg::filt_mode_e                               mode,
  input  logic signed [smooth_pkg::TAP_COUNT-1:0][SAMPLE_WIDTH-1:0] taps,
  input  logic                                                 shifted,
  output logic                                                 out_valid,
  output logic signed [SAMPLE_WIDTH-1:0]                       out_sample
);

  import smooth_pkg::*;

  localparam int GUARD_BITS = 4;  // room for a 16 tap sum
  localparam int ACC_W      = SAMPLE_WIDTH + GUARD_BITS;

  typedef logic signed [ACC_W-1:0] acc_t;

  acc_t       tap_ext [TAP_COUNT];
  acc_t       run_sum [TAP_COUNT];
  acc_t       sum_next;
  acc_t       sum_q;
  filt_mode_e mode_q;
  logic       s1_valid;
  acc_t       scaled;

  // ************************************************************
  // stage 1, mode-selected sum
  // ************************************************************

  always_comb begin
    for (int k = 0; k < TAP_COUNT; k++) begin
      tap_ext[k] = {{GUARD_BITS{taps[k][SAMPLE_WIDTH-1]}}, taps[k]};
    end
  end

  // running sums, run_sum[n-1] covers taps 0..n-1
  always_comb begin
    run_sum[0] = tap_ext[0];
    for (int k = 1; k < TAP_COUNT; k++) begin
      run_sum[k] = run_sum[k-1] + tap_ext[k];
    end
  end

  always_comb begin
    case (mode)
      MODE_AVG2:    sum_next = run_sum[1];
      MODE_AVG4:    sum_next = run_sum[3];
      MODE_AVG8:    sum_next = run_sum[7];
      MODE_AVG16:   sum_next = run_sum[15];
      MODE_WEIGHT4: begin
        // 1/8 1/8 1/4 1/2, newest first
        sum_next = (tap_ext[0] >>> 3) + (tap_ext[1] >>> 3) +
                   (tap_ext[2] >>> 2) + (tap_ext[3] >>> 1);
      end
      MODE_WEIGHT5: begin
        sum_next = (tap_ext[0] >>> 4) + (tap_ext[1] >>> 4) +
                   (tap_ext[2] >>> 3) + (tap_ext[3] >>> 2) +
                   (tap_ext[4] >>> 1);
      end
      default:      sum_next = tap_ext[0];  // both bypass codes
    endcase
  end

  always_ff @(posedge clk) begin
    if (shifted) begin
      sum_q  <= sum_next;
      mode_q <= mode;  // mode follows its own sample
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n || flush) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= shifted;
    end
  end

  // ************************************************************
  // stage 2, scale and truncate
  // ************************************************************

  always_comb begin
    case (mode_q)
      MODE_AVG2:  scaled = sum_q >>> 1;
      MODE_AVG4:  scaled = sum_q >>> 2;
      MODE_AVG8:  scaled = sum_q >>> 3;
      MODE_AVG16: scaled = sum_q >>> 4;
      default:    scaled = sum_q;  // weights already applied
    endcase
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      out_sample <= scaled[SAMPLE_WIDTH-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n || flush) begin
      out_valid <= 1'b0;  // in-flight samples dropped on flush
    end else begin
      out_valid <= s1_valid;
    end
  end

endmodule

// ==== rtl/smooth_top.sv ====
`timescale 1ns/1ps

module smooth_top #(
  parameter int SAMPLE_WIDTH = 24
) (
  input  logic                           clk,
  input  logic                           reset_n,
  input  smooth_pkg::axil_req_t          ctrl_req,
  output smooth_pkg::axil_rsp_t          ctrl_rsp,
  input  logic                           in_valid,
  input  logic signed [SAMPLE_WIDTH-1:0] in_sample,
  output logic                           out_valid,
  output logic signed [SAMPLE_WIDTH-1:0] out_sample
);

  import smooth_pkg::*;

  filt_mode_e mode;
  logic       flush;
  logic       shifted;
  logic signed [TAP_COUNT-1:0][SAMPLE_WIDTH-1:0] taps;

  // ************************************************************
  // control registers
  // ************************************************************

  axil_ctrl_regs i_regs (
    .clk       (clk),
    .reset_n   (reset_n),
    .ctrl_req  (ctrl_req),
    .out_valid (out_valid),  // counted for COUNT
    .ctrl_rsp  (ctrl_rsp),
    .mode      (mode),
    .flush     (flush)
  );

  // ************************************************************
  // sample path
  // ************************************************************

  tap_delay_line #(
    .SAMPLE_WIDTH (SAMPLE_WIDTH)
  ) i_delay (
    .clk       (clk),
    .reset_n   (reset_n),
    .flush     (flush),
    .in_valid  (in_valid),
    .in_sample (in_sample),
    .taps      (taps),
    .shifted   (shifted)
  );

  tap_filter #(
    .SAMPLE_WIDTH (SAMPLE_WIDTH)
  ) i_filter (
    .clk        (clk),
    .reset_n    (reset_n),
    .flush      (flush),
    .mode       (mode),
    .taps       (taps),
    .shifted    (shifted),
    .out_valid  (out_valid),
    .out_sample (out_sample)
  );

endmodule

// ==== tb/smooth_properties.sv ====
`timescale 1ns/1ps

module smooth_properties (
  input logic                  clk,
  input logic                  reset_n,
  input smooth_pkg::axil_req_t ctrl_req,
  input smooth_pkg::axil_rsp_t ctrl_rsp,
  input logic                  in_valid,
  input logic                  out_valid,
  input logic                  flush
);

  import smooth_pkg::*;

  // ************************************************************
  // sample path timing
  // ************************************************************

  a_out_latency: assert property (@(posedge clk) disable iff (!reset_n)
    ($past(in_valid, 3) && !$past(flush, 1) && !$past(flush, 2) && !$past(flush, 3))
      |-> out_valid)
    else $error("out_valid missing three cycles after in_valid");

  a_out_cause: assert property (@(posedge clk) disable iff (!reset_n)
    out_valid |-> $past(in_valid, 3))
    else $error("out_valid without a sample three cycles earlier");

  a_flush_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    flush |=> !flush)
    else $error("flush longer than one cycle");

  // ************************************************************
  // AXI4-Lite handshake
  // ************************************************************

  a_bvalid_hold: assert property (@(posedge clk) disable iff (!reset_n)
    (ctrl_rsp.bvalid && !ctrl_req.bready) |=> ctrl_rsp.bvalid)
    else $error("bvalid dropped before bready");

  a_rvalid_hold: assert property (@(posedge clk) disable iff (!reset_n)
    (ctrl_rsp.rvalid && !ctrl_req.rready) |=> (ctrl_rsp.rvalid && $stable(ctrl_rsp.rdata)))
    else $error("rvalid or rdata changed before rready");

  a_reset_quiet: assert property (@(posedge clk)
    !reset_n |=> (!ctrl_rsp.awready && !ctrl_rsp.wready && !ctrl_rsp.bvalid &&
                  !ctrl_rsp.arready && !ctrl_rsp.rvalid && !out_valid && !flush))
    else $error("activity during reset");

endmodule

bind smooth_top smooth_properties i_props (
  .clk       (clk),
  .reset_n   (reset_n),
  .ctrl_req  (ctrl_req),
  .ctrl_rsp  (ctrl_rsp),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .flush     (flush)
);

// ==== tb/tb_smooth.sv ====
`timescale 1ns/1ps

module tb_smooth;

  import smooth_pkg::*;

  localparam int SAMPLE_WIDTH = 24;
  localparam int WAIT_LIMIT   = 200;  // cycles per wait loop
  localparam int STREAM_LEN   = 40;

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

  logic       clk;
  logic       reset_n;
  axil_req_t  ctrl_req;
  axil_rsp_t  ctrl_rsp;
  logic       in_valid;
  sample_t    in_sample;
  logic       out_valid;
  sample_t    out_sample;

  integer     seed;
  int         error_count;
  int         timeout_count;
  int         checked_count;
  int         seen_count;
  longint     hist [TAP_COUNT];  // model history with hist[0] newest
  filt_mode_e tb_mode;
  sample_t    exp_q [$];

  smooth_top #(
    .SAMPLE_WIDTH (SAMPLE_WIDTH)
  ) i_dut (
    .clk        (clk),
    .reset_n    (reset_n),
    .ctrl_req   (ctrl_req),
    .ctrl_rsp   (ctrl_rsp),
    .in_valid   (in_valid),
    .in_sample  (in_sample),
    .out_valid  (out_valid),
    .out_sample (out_sample)
  );

  always #20 clk = ~clk;

  // ************************************************************
  // reference model
  // ************************************************************

  // floor of the mean over the newest n taps
  function automatic longint floor_mean(input int n);
    longint sum;
    longint quot;
    sum = 0;
    for (int k = 0; k < n; k++) begin
      sum += hist[k];
    end
    quot = sum / n;
    if (sum < 0 && (sum % n) != 0) begin
      quot -= 1;  // division rounds toward zero
    end
    return quot;
  endfunction

  function automatic longint filter_model(input filt_mode_e m);
    longint res;
    case (m)
      MODE_AVG2:    res = floor_mean(2);
      MODE_AVG4:    res = floor_mean(4);
      MODE_AVG8:    res = floor_mean(8);
      MODE_AVG16:   res = floor_mean(16);
      MODE_WEIGHT4: res = (hist[0] >>> 3) + (hist[1] >>> 3) + (hist[2] >>> 2) + (hist[3] >>> 1);
      MODE_WEIGHT5: begin
        res = (hist[0] >>> 4) + (hist[1] >>> 4) + (hist[2] >>> 3) +
              (hist[3] >>> 2) + (hist[4] >>> 1);
      end
      default:      res = hist[0];
    endcase
    return res;
  endfunction

  task automatic clear_history();
    for (int k = 0; k < TAP_COUNT; k++) begin
      hist[k] = 0;
    end
  endtask

  // ************************************************************
  // checking and reporting
  // ************************************************************

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      error_count++;
      $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic finish_run();
    $display("Summary: %0d mismatches, %0d timeouts, %0d outputs checked",
             error_count, timeout_count, checked_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    timeout_count++;
    $display("Timeout: no %s within %0d cycles at %0t ns", what, WAIT_LIMIT, $time);
    finish_run();
  endtask

  always @(negedge clk) begin
    sample_t expected;
    if (reset_n && out_valid) begin
      seen_count++;
      if (exp_q.size() == 0) begin
        error_count++;
        $display("Output sample at %0t ns with no sample pending", $time);
      end else begin
        expected = exp_q.pop_front();
        checked_count++;
        check_value(32'(out_sample), 32'(expected), "filtered sample");
      end
    end
  end

  // ************************************************************
  // AXI4-Lite master tasks
  // ************************************************************

  task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                            output axil_resp_t resp);
    int cnt;
    @(posedge clk);
    #2;
    ctrl_req.awvalid = 1'b1;
    ctrl_req.awaddr  = addr;
    ctrl_req.wvalid  = 1'b1;
    ctrl_req.wdata   = data;
    ctrl_req.wstrb   = 4'hf;
    ctrl_req.bready  = 1'b0;  // response held off for a cycle
    cnt = 0;
    while (!(ctrl_rsp.awready && ctrl_rsp.wready) && cnt < WAIT_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (!(ctrl_rsp.awready && ctrl_rsp.wready)) report_timeout("write acceptance");
    @(posedge clk);  // address and data taken here
    #2;
    ctrl_req.awvalid = 1'b0;
    ctrl_req.wvalid  = 1'b0;
    cnt = 0;
    while (!ctrl_rsp.bvalid && cnt < WAIT_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (!ctrl_rsp.bvalid) report_timeout("write response");
    resp = ctrl_rsp.bresp;
    @(posedge clk);
    #2;
    if (!ctrl_rsp.bvalid) begin
      error_count++;
      $display("bvalid dropped while bready was low at %0t ns", $time);
    end
    ctrl_req.bready = 1'b1;
    @(posedge clk);
    #2;
    ctrl_req.bready = 1'b0;
  endtask

  // hold keeps rready low for that many cycles once rvalid is up
  task automatic axil_read(input axil_addr_t addr, input int hold,
                           output axil_data_t data, output axil_resp_t resp);
    int cnt;
    @(posedge clk);
    #2;
    ctrl_req.arvalid = 1'b1;
    ctrl_req.araddr  = addr;
    ctrl_req.rready  = 1'b0;
    cnt = 0;
    while (!ctrl_rsp.arready && cnt < WAIT_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (!ctrl_rsp.arready) report_timeout("read address acceptance");
    @(posedge clk);
    #2;
    ctrl_req.arvalid = 1'b0;
    cnt = 0;
    while (!ctrl_rsp.rvalid && cnt < WAIT_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (!ctrl_rsp.rvalid) report_timeout("read data");
    data = ctrl_rsp.rdata;
    resp = ctrl_rsp.rresp;
    repeat (hold) begin
      @(negedge clk);
      if (!ctrl_rsp.rvalid) begin
        error_count++;
        $display("rvalid dropped while rready was low at %0t ns", $time);
      end
      check_value(ctrl_rsp.rdata, data, "rdata under back-pressure");
    end
    @(posedge clk);
    #2;
    ctrl_req.rready = 1'b1;
    @(posedge clk);
    #2;
    ctrl_req.rready = 1'b0;
  endtask

  task automatic write_mode(input filt_mode_e m, input bit do_flush);
    axil_resp_t resp;
    axil_write(ADDR_CTRL, {27'd0, do_flush, 1'b0, m}, resp);
    check_value(32'(resp), 32'(RESP_OKAY), "CTRL write response");
    tb_mode = m;
    if (do_flush) clear_history();
  endtask

  // ************************************************************
  // sample stream
  // ************************************************************

  function automatic sample_t random_sample(input int idx);
    sample_t value;
    if (idx >= 20 && idx < 36) value = {1'b0, {(SAMPLE_WIDTH-1){1'b1}}};  // full-scale run
    else if (idx % 10 == 3)    value = {1'b1, {(SAMPLE_WIDTH-1){1'b0}}};
    else if (idx % 10 == 7)    value = {1'b0, {(SAMPLE_WIDTH-1){1'b1}}};
    else                       value = sample_t'($random(seed));
    return value;
  endfunction

  task automatic send_sample(input sample_t value);
    @(posedge clk);
    #2;
    in_valid  = 1'b1;
    in_sample = value;
    for (int k = TAP_COUNT - 1; k > 0; k--) begin
      hist[k] = hist[k-1];
    end
    hist[0] = longint'(value);
    exp_q.push_back(sample_t'(filter_model(tb_mode)));
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
      in_valid = 1'b0;
    end
  endtask

  task automatic stream_random(input int count, input bit with_gaps);
    int gap;
    for (int i = 0; i < count; i++) begin
      send_sample(random_sample(i));
      if (with_gaps) begin
        gap = int'($unsigned($random(seed)) % 4);
        if (gap > 0) idle_cycles(gap);
      end
    end
    idle_cycles(1);
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while (exp_q.size() != 0 && cnt < WAIT_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (exp_q.size() != 0) report_timeout("drain of pending outputs");
    repeat (4) @(negedge clk);  // catch stray outputs
  endtask

  // ************************************************************
  // test sequence
  // ************************************************************

  initial begin
    axil_data_t rd_data;
    axil_resp_t resp;
    filt_mode_e avg_modes [4];
    filt_mode_e wgt_modes [3];
    avg_modes = '{MODE_AVG2, MODE_AVG4, MODE_AVG8, MODE_AVG16};
    wgt_modes = '{MODE_WEIGHT4, MODE_WEIGHT5, MODE_BYPASS_ALT};
    seed          = 55927;
    clk           = 1'b0;
    reset_n       = 1'b0;
    ctrl_req      = '0;
    in_valid      = 1'b0;
    in_sample     = '0;
    error_count   = 0;
    timeout_count = 0;
    checked_count = 0;
    seen_count    = 0;
    tb_mode       = MODE_BYPASS;
    clear_history();
    repeat (3) @(posedge clk);
    #2;
    reset_n = 1'b1;

    axil_read(ADDR_CTRL, 0, rd_data, resp);
    check_value(rd_data, 32'(MODE_BYPASS), "CTRL after reset");
    axil_read(ADDR_COUNT, 0, rd_data, resp);
    check_value(rd_data, 32'd0, "COUNT after reset");
    stream_random(20, 1'b0);
    wait_drain();

    foreach (avg_modes[i]) begin
      write_mode(avg_modes[i], 1'b0);
      write_mode(avg_modes[i], 1'b1);
      stream_random(STREAM_LEN, 1'b0);
      wait_drain();
    end

    foreach (wgt_modes[i]) begin
      write_mode(wgt_modes[i], 1'b1);
      stream_random(STREAM_LEN / 2, 1'b0);
      stream_random(STREAM_LEN / 2, 1'b1);
      wait_drain();
    end

    // flush between two bursts with nothing in flight
    write_mode(MODE_AVG8, 1'b1);
    stream_random(12, 1'b0);
    wait_drain();
    write_mode(MODE_AVG8, 1'b1);
    stream_random(12, 1'b1);
    wait_drain();

    axil_read(ADDR_COUNT, 0, rd_data, resp);
    check_value(rd_data, 32'(seen_count), "COUNT against observed outputs");
    axil_read(ADDR_CTRL, 0, rd_data, resp);
    check_value(rd_data, 32'(MODE_AVG8), "CTRL readback with flush bit clear");
    axil_write(4'h8, 32'h0000_0005, resp);
    check_value(32'(resp), 32'(RESP_SLVERR), "write response to unknown address");
    axil_read(4'h8, 0, rd_data, resp);
    check_value(32'(resp), 32'(RESP_SLVERR), "read response from unknown address");
    check_value(rd_data, 32'd0, "read data from unknown address");
    axil_read(ADDR_CTRL, 0, rd_data, resp);
    check_value(rd_data, 32'(MODE_AVG8), "CTRL after unknown address write");
    axil_read(ADDR_COUNT, 6, rd_data, resp);
    check_value(rd_data, 32'(seen_count), "COUNT read with rready held low");

    finish_run();
  end

endmodule

// ==== all.f ====
rtl/smooth_pkg.sv
rtl/axil_ctrl_regs.sv
rtl/tap_delay_line.sv
rtl/tap_filter.sv
rtl/smooth_top.sv
tb/smooth_properties.sv
tb/tb_smooth.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the smoothing testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_smooth --Mdir "$BUILD" -o tb_smooth -f all.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$BUILD/tb_smooth" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
  echo "test failed"
  exit 1
fi

echo "test passed"
exit 0
